// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [31:0] slot_t;

    // address bit that picks the instruction slot in a read word
    localparam int lane_bit = 2;

    // one read word, either a whole doubleword or two instruction slots
    // slot 0 is the low half
    typedef union packed {
        logic [63:0]     dword;
        slot_t [1:0]     slot;
    } rd_word_u;

    // read address channel, driven by the fetch unit
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } rd_req_t;

    // read data channel, driven by memory
    typedef struct packed {
        logic     valid;
        rd_word_u data;
    } rd_resp_t;

endpackage

`default_nettype wire

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // core word and instruction widths
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;

    // pc after reset, widened to the core word
    localparam xlen_t reset_pc = xlen_t'(32'h8000_0000);

    // sequential advance, no compressed instructions
    localparam xlen_t inst_bytes = xlen_t'(4);

    // fetch controller states
    typedef logic [1:0] fstate_t;

    localparam fstate_t fs_idle = 2'd0;
    localparam fstate_t fs_addr = 2'd1;
    localparam fstate_t fs_data = 2'd2;

    // control transfer info from the memory stage and csr file
    typedef struct packed {
        logic  jal;
        logic  jalr;
        logic  branch;
        logic  trap;
        // pc of the instruction in the memory stage
        xlen_t mem_pc;
        xlen_t imm;
        xlen_t r1_data;
        // branch compare result, zero means taken
        xlen_t alu_res;
        xlen_t mtvec;
    } redirect_t;

    // what decode sees each cycle
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } fetch_out_t;

endpackage

`default_nettype wire

// File: fetch/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  logic               clk,
    input  logic               rst_n_i,
    input  fetch_pkg::xlen_t   pc_i,
    input  logic               redirect_taken_i,
    input  logic               stall_i,
    output bus_pkg::rd_req_t   rd_req_o,
    input  logic               rd_req_ready_i,
    input  logic               rd_resp_valid_i,
    output logic               rd_resp_ready_o,
    output logic               deliver_o
);

    import fetch_pkg::*;

    fstate_t state_q;
    fstate_t state_d;

    // request address, captured while in ADDR and held through DATA
    xlen_t   req_addr_q;
    // high once the address of the current request has been captured
    logic    addr_held_q;
    // outstanding read was overtaken by a redirect
    logic    stale_q;

    logic    req_hs;
    logic    resp_hs;
    logic    issue;
    logic    addr_live;

    assign req_hs  = rd_req_o.valid && rd_req_ready_i;
    assign resp_hs = rd_resp_valid_i && rd_resp_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fs_idle: begin
                state_d = fs_addr;
            end
            fs_addr: begin
                if (req_hs) begin
                    state_d = fs_data;
                end
            end
            fs_data: begin
                if (resp_hs) begin
                    state_d = fs_addr;
                end
            end
            default: begin
                state_d = fs_idle;
            end
        endcase
    end

    // a new request starts whenever ADDR is entered
    assign issue = (state_q != fs_addr) && (state_d == fs_addr);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= fs_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // first ADDR cycle presents the pc that was just written, later
    // cycles keep that value until memory takes it
    assign addr_live = (state_q == fs_addr) && !addr_held_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_held_q <= 1'b0;
        end else begin
            addr_held_q <= (state_q == fs_addr);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fs_addr) begin
            req_addr_q <= rd_req_o.addr;
        end
    end

    assign rd_req_o.valid = (state_q == fs_addr);
    assign rd_req_o.addr  = addr_live ? pc_i : req_addr_q;

    assign rd_resp_ready_o = (state_q == fs_data);

    // any redirect while a read is pending makes its data useless
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stale_q <= 1'b0;
        end else if (issue) begin
            stale_q <= 1'b0;
        end else if (redirect_taken_i && (state_q != fs_idle)) begin
            stale_q <= 1'b1;
        end
    end

    // response is still taken under stall or redirect, just not passed on
    assign deliver_o = resp_hs && !stale_q && !redirect_taken_i && !stall_i;

endmodule

`default_nettype wire

// File: fetch/inst_align.sv
`timescale 1ns/1ps
`default_nettype none

module inst_align (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  deliver_i,
    input  fetch_pkg::xlen_t      req_addr_i,
    input  bus_pkg::rd_word_u     rd_data_i,
    output fetch_pkg::fetch_out_t fetch_o
);

    import fetch_pkg::*;
    import bus_pkg::*;

    inst_t lane_inst;

    // address bit 2 picks the upper or lower word of the doubleword
    assign lane_inst = rd_data_i.slot[req_addr_i[lane_bit]];

    // one cycle of valid per delivery, bubble otherwise
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fetch_o <= '0;
        end else if (deliver_i) begin
            fetch_o.valid <= 1'b1;
            fetch_o.pc    <= req_addr_i;
            fetch_o.inst  <= lane_inst;
        end else begin
            fetch_o <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rv64_fetch.f
common/fetch_pkg.sv
common/bus_pkg.sv
source/pc_select.sv
fetch/fetch_ctrl.sv
fetch/inst_align.sv
source/fetch_top.sv
testbench/mem_responder.sv
testbench/fetch_tb.sv

// File: source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                  clk,
    input  logic                  rst_n_i,

    // core side
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  stall_i,
    output fetch_pkg::fetch_out_t fetch_o,

    // read bus
    output bus_pkg::rd_req_t      rd_req_o,
    input  logic                  rd_req_ready_i,
    input  bus_pkg::rd_resp_t     rd_resp_i,
    output logic                  rd_resp_ready_o
);

    import fetch_pkg::*;

    xlen_t pc;
    logic  redirect_taken;
    logic  deliver;

    pc_select pc_select_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_i       (redirect_i),
        .deliver_i        (deliver),
        .pc_o             (pc),
        .redirect_taken_o (redirect_taken)
    );

    fetch_ctrl fetch_ctrl_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .pc_i             (pc),
        .redirect_taken_i (redirect_taken),
        .stall_i          (stall_i),
        .rd_req_o         (rd_req_o),
        .rd_req_ready_i   (rd_req_ready_i),
        .rd_resp_valid_i  (rd_resp_i.valid),
        .rd_resp_ready_o  (rd_resp_ready_o),
        .deliver_o        (deliver)
    );

    // address is held through DATA, so it still names the returning word
    inst_align inst_align_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .deliver_i  (deliver),
        .req_addr_i (rd_req_o.addr),
        .rd_data_i  (rd_resp_i.data),
        .fetch_o    (fetch_o)
    );

endmodule

`default_nettype wire

// File: source/pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module pc_select (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  deliver_i,
    output fetch_pkg::xlen_t      pc_o,
    output logic                  redirect_taken_o
);

    import fetch_pkg::*;

    xlen_t pc_q;
    xlen_t jump_target;
    xlen_t jalr_sum;
    xlen_t redirect_target;
    logic  branch_taken;
    logic  jump_taken;

    // branch compare result of zero means the branch is taken
    assign branch_taken = redirect_i.branch && (redirect_i.alu_res == '0);
    assign jump_taken   = redirect_i.jal || branch_taken;

    assign jump_target = redirect_i.mem_pc + redirect_i.imm;
    assign jalr_sum    = redirect_i.r1_data + redirect_i.imm;

    // highest priority first: jal or taken branch, jalr, trap
    always_comb begin
        if (jump_taken) begin
            redirect_target = jump_target;
        end else if (redirect_i.jalr) begin
            // jalr clears bit 0 of the sum
            redirect_target = {jalr_sum[63:1], 1'b0};
        end else begin
            redirect_target = redirect_i.mtvec;
        end
    end

    assign redirect_taken_o = jump_taken || redirect_i.jalr || redirect_i.trap;

    // a redirect always overrides the sequential step
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= reset_pc;
        end else if (redirect_taken_o) begin
            pc_q <= redirect_target;
        end else if (deliver_i) begin
            pc_q <= pc_q + inst_bytes;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    import fetch_pkg::*;
    import bus_pkg::*;

    localparam int unsigned seed             = 32'h653963f8;
    localparam int          total_deliveries = 400;
    // worst case of about 10 bus cycles per delivery, plus margin
    localparam int          cycle_limit      = total_deliveries * 10 + 2000;

    // redirect stimulus mixes
    localparam int mode_none      = 0;
    localparam int mode_jump      = 1;
    localparam int mode_jalr_trap = 2;
    localparam int mode_any       = 3;

    localparam int k_jal      = 0;
    localparam int k_br_taken = 1;
    localparam int k_br_not   = 2;
    localparam int k_combo    = 3;
    localparam int k_jalr     = 4;
    localparam int k_trap     = 5;

    logic       clk;
    logic       rst_n_i;
    redirect_t  redirect_i;
    logic       stall_i;
    fetch_out_t fetch_o;
    rd_req_t    rd_req_o;
    logic       rd_req_ready_i;
    rd_resp_t   rd_resp_i;
    logic       rd_resp_ready_o;

    // reference model state
    xlen_t model_pc;
    xlen_t req_addr_m;
    logic  req_open;
    logic  stale_m;
    logic  data_m;
    logic  prev_req_valid;
    logic  prev_req_hs;
    logic  prev_resp_hs;
    logic  exp_valid;
    xlen_t exp_pc;
    inst_t exp_inst;

    int cycle_count  = 0;
    int delivered    = 0;
    int stale_drops  = 0;
    int stall_drops  = 0;
    int check_count  = 0;
    int error_count  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int err_mark     = 0;

    fetch_top fetch_top_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect_i),
        .stall_i         (stall_i),
        .fetch_o         (fetch_o),
        .rd_req_o        (rd_req_o),
        .rd_req_ready_i  (rd_req_ready_i),
        .rd_resp_i       (rd_resp_i),
        .rd_resp_ready_o (rd_resp_ready_o)
    );

    mem_responder mem_responder_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rd_req_i        (rd_req_o),
        .rd_req_ready_o  (rd_req_ready_i),
        .rd_resp_o       (rd_resp_i),
        .rd_resp_ready_i (rd_resp_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        check_count++;
        assert (got === expected) else begin
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_count++;
        assert (cond === 1'b1) else begin
            $display("Error at %0t ns: %s", $time, what);
            error_count++;
        end
    endtask

    // instruction expected at a word address, same hash as the memory model
    function automatic inst_t expected_word(input xlen_t addr);
        inst_t h;
        h = addr[31:0] * 32'h9e37_79b1;
        h = h ^ (addr[63:32] * 32'h85eb_ca6b);
        h = h ^ (h >> 15);
        return h;
    endfunction

    function automatic logic redirect_applies(input redirect_t r);
        return r.jal || (r.branch && r.alu_res == '0) || r.jalr || r.trap;
    endfunction

    // jal or taken branch first, then jalr, then trap
    function automatic xlen_t redirect_dest(input redirect_t r);
        xlen_t sum;
        sum    = r.r1_data + r.imm;
        sum[0] = 1'b0;
        if (r.jal || (r.branch && r.alu_res == '0)) begin
            return r.mem_pc + r.imm;
        end else if (r.jalr) begin
            return sum;
        end
        return r.mtvec;
    endfunction

    function automatic xlen_t window_addr();
        return reset_pc + xlen_t'(4 * $urandom_range(0, 255));
    endfunction

    function automatic redirect_t make_redirect(input int kind);
        redirect_t r;
        r         = '0;
        r.mem_pc  = window_addr();
        r.imm     = xlen_t'(4 * $urandom_range(0, 63));
        r.r1_data = window_addr();
        // odd compare result, so a plain branch is not taken
        r.alu_res = {$urandom, $urandom} | 64'h1;
        r.mtvec   = window_addr();
        case (kind)
            k_jal: r.jal = 1'b1;
            k_br_taken: begin
                r.branch  = 1'b1;
                r.alu_res = '0;
            end
            k_br_not: r.branch = 1'b1;
            k_combo: begin
                r.jal  = 1'b1;
                r.jalr = 1'b1;
                r.trap = 1'b1;
            end
            k_jalr: begin
                r.jalr   = 1'b1;
                r.imm[0] = $urandom_range(0, 1);
            end
            default: r.trap = 1'b1;
        endcase
        return r;
    endfunction

    function automatic int pick_kind(input int mode);
        case (mode)
            mode_jump:      return $urandom_range(k_jal, k_combo);
            mode_jalr_trap: return $urandom_range(k_jalr, k_trap);
            default:        return $urandom_range(k_jal, k_trap);
        endcase
    endfunction

    // random redirects and stalls until the delivery count reaches target
    task automatic run_phase(input int target, input int mode, input logic stall_on);
        while (delivered < target) begin
            @(posedge clk);
            if (mode != mode_none && $urandom_range(0, 11) == 0) begin
                redirect_i <= make_redirect(pick_kind(mode));
            end else begin
                redirect_i <= '0;
            end
            stall_i <= stall_on && ($urandom_range(0, 5) == 0);
        end
        @(posedge clk);
        redirect_i <= '0;
        stall_i    <= 1'b0;
    endtask

    task automatic pulse_redirect(input redirect_t r);
        @(posedge clk);
        redirect_i <= r;
        @(posedge clk);
        redirect_i <= '0;
        // give the redirected fetch time to reach decode
        repeat (12) @(posedge clk);
    endtask

    task automatic begin_test();
        err_mark = error_count;
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (error_count > err_mark) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, error_count - err_mark);
        end else begin
            $display("test %0d %s: passed", num, name);
        end
    endtask

    task automatic finish_run();
        $display("tests %0d, failed %0d, checks %0d, errors %0d, deliveries %0d",
                 tests_run, tests_failed, check_count, error_count, delivered);
        if (error_count == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // reference model, sampled mid cycle when every input and output is settled
    always @(negedge clk) begin : monitor
        logic  redir;
        logic  resp_hs;
        logic  due;
        xlen_t dest;
        if (!rst_n_i) begin
            model_pc       = reset_pc;
            req_open       = 1'b0;
            stale_m        = 1'b0;
            data_m         = 1'b0;
            prev_req_valid = 1'b0;
            prev_req_hs    = 1'b0;
            prev_resp_hs   = 1'b0;
            exp_valid      = 1'b0;
            exp_pc         = '0;
            exp_inst       = '0;
        end else begin
            cycle_count++;
            // decode sees an all-zero bundle whenever nothing is delivered
            compare_field("fetch_o.valid", fetch_o.valid, exp_valid);
            compare_field("fetch_o.pc", fetch_o.pc, exp_pc);
            compare_field("fetch_o.inst", fetch_o.inst, exp_inst);
            exp_valid = 1'b0;
            exp_pc    = '0;
            exp_inst  = '0;
            redir     = redirect_applies(redirect_i);
            dest      = redirect_dest(redirect_i);
            check_true(!(rd_req_o.valid && rd_resp_ready_o),
                       "request valid and response ready are high together");
            // ready from the cycle after the request handshake up to the response
            compare_field("rd_resp_ready_o", rd_resp_ready_o, data_m);
            if (prev_resp_hs) begin
                check_true(rd_req_o.valid,
                           "no request was raised in the cycle after a response");
            end
            if (rd_req_o.valid && !prev_req_valid) begin
                check_true(!req_open, "a new request was issued while a read is outstanding");
                compare_field("rd_req_o.addr", rd_req_o.addr, model_pc);
                req_addr_m = model_pc;
                req_open   = 1'b1;
                stale_m    = 1'b0;
            end else if (rd_req_o.valid) begin
                compare_field("rd_req_o.addr", rd_req_o.addr, req_addr_m);
            end else begin
                check_true(!prev_req_valid || prev_req_hs,
                           "request valid dropped before memory accepted it");
            end
            // a redirect anywhere between issue and response kills the fetch
            if (req_open && redir) begin
                stale_m = 1'b1;
            end
            resp_hs = rd_resp_i.valid && rd_resp_ready_o;
            due     = 1'b0;
            if (resp_hs) begin
                check_true(req_open, "a response was accepted with no read outstanding");
                due = !stale_m && !redir && !stall_i;
                if (due) begin
                    exp_valid = 1'b1;
                    exp_pc    = req_addr_m;
                    exp_inst  = expected_word(req_addr_m);
                    delivered++;
                end else if (stale_m || redir) begin
                    stale_drops++;
                end else begin
                    stall_drops++;
                end
                req_open = 1'b0;
            end
            if (redir) begin
                model_pc = dest;
            end else if (due) begin
                model_pc = model_pc + 64'd4;
            end
            if (rd_req_o.valid && rd_req_ready_i) begin
                data_m = 1'b1;
            end else if (resp_hs) begin
                data_m = 1'b0;
            end
            prev_req_valid = rd_req_o.valid;
            prev_req_hs    = rd_req_o.valid && rd_req_ready_i;
            prev_resp_hs   = resp_hs;
        end
    end

    initial begin : watchdog
        wait (rst_n_i === 1'b1);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout: only %0d of %0d deliveries after %0d cycles",
                 delivered, total_deliveries, cycle_count);
        error_count++;
        finish_run();
    end

    initial begin : stimulus
        redirect_t   r;
        int unsigned seed_ret;
        int          stale_mark;
        rst_n_i    = 1'b0;
        redirect_i = '0;
        stall_i    = 1'b0;
        seed_ret   = $urandom(seed);

        begin_test();
        @(posedge clk);
        @(negedge clk);
        check_true(!fetch_o.valid && !rd_req_o.valid && !rd_resp_ready_o,
                   "outputs are not idle during reset");
        @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_true(!fetch_o.valid && !rd_req_o.valid && !rd_resp_ready_o,
                   "outputs are not idle in the first cycle out of reset");
        @(negedge clk);
        check_true(rd_req_o.valid, "no request was raised in the cycle after reset");
        compare_field("rd_req_o.addr", rd_req_o.addr, reset_pc);
        end_test(1, "reset");

        begin_test();
        run_phase(100, mode_none, 1'b0);
        end_test(2, "sequential delivery");

        // each jump kind once, then a random mix
        begin_test();
        pulse_redirect(make_redirect(k_jal));
        pulse_redirect(make_redirect(k_br_taken));
        pulse_redirect(make_redirect(k_br_not));
        pulse_redirect(make_redirect(k_combo));
        run_phase(170, mode_jump, 1'b0);
        end_test(3, "jal and branch");

        begin_test();
        r        = make_redirect(k_jalr);
        r.imm[0] = 1'b1;
        pulse_redirect(r);
        pulse_redirect(make_redirect(k_trap));
        run_phase(240, mode_jalr_trap, 1'b0);
        end_test(4, "jalr and trap");

        begin_test();
        stale_mark = stale_drops;
        run_phase(310, mode_any, 1'b0);
        check_true(stale_drops > stale_mark, "no response was dropped as stale in this test");
        end_test(5, "stale response");

        begin_test();
        run_phase(total_deliveries, mode_any, 1'b1);
        check_true(stall_drops > 0, "no response was ever dropped under stall");
        end_test(6, "stall");

        finish_run();
    end

endmodule

`default_nettype wire

// File: testbench/mem_responder.sv
`timescale 1ns/1ps
`default_nettype none

module mem_responder (
    input  logic              clk,
    input  logic              rst_n_i,
    input  bus_pkg::rd_req_t  rd_req_i,
    output logic              rd_req_ready_o,
    output bus_pkg::rd_resp_t rd_resp_o,
    input  logic              rd_resp_ready_i
);

    import bus_pkg::*;

    localparam logic [1:0] ms_accept = 2'd0;
    localparam logic [1:0] ms_wait   = 2'd1;
    localparam logic [1:0] ms_resp   = 2'd2;

    logic [1:0] state_q;
    int         delay_q;
    addr_t      addr_q;

    // every 32-bit word of memory is a hash of its own address
    function automatic slot_t word_hash(input addr_t addr);
        slot_t h;
        h = addr[31:0] * 32'h9e37_79b1;
        h = h ^ (addr[63:32] * 32'h85eb_ca6b);
        h = h ^ (h >> 15);
        return h;
    endfunction

    function automatic rd_word_u read_dword(input addr_t addr);
        rd_word_u w;
        addr_t    base;
        base      = {addr[63:3], 3'b000};
        w.slot[0] = word_hash(base);
        w.slot[1] = word_hash(base + 64'd4);
        return w;
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= ms_accept;
            delay_q        <= 0;
            addr_q         <= '0;
            rd_req_ready_o <= 1'b0;
            rd_resp_o      <= '0;
        end else begin
            case (state_q)
                ms_accept: begin
                    if (rd_req_i.valid && rd_req_ready_o) begin
                        rd_req_ready_o <= 1'b0;
                        addr_q         <= rd_req_i.addr;
                        delay_q        <= $urandom_range(0, 3);
                        state_q        <= ms_wait;
                    end else if (rd_req_i.valid) begin
                        // ready stays low for the remaining accept delay
                        if (delay_q == 0) begin
                            rd_req_ready_o <= 1'b1;
                        end else begin
                            delay_q <= delay_q - 1;
                        end
                    end
                end
                ms_wait: begin
                    if (delay_q == 0) begin
                        rd_resp_o.valid <= 1'b1;
                        rd_resp_o.data  <= read_dword(addr_q);
                        state_q         <= ms_resp;
                    end else begin
                        delay_q <= delay_q - 1;
                    end
                end
                ms_resp: begin
                    if (rd_resp_ready_i) begin
                        rd_resp_o <= '0;
                        delay_q   <= $urandom_range(0, 3);
                        state_q   <= ms_accept;
                    end
                end
                default: begin
                    state_q <= ms_accept;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
